// ==== sim.f ====
verilog/board_audio_pkg.sv
verilog/inmp441_mic_i2s_receiver.sv
verilog/sound_gain_stage.sv
verilog/level_meter.sv
verilog/i2s_audio_out.sv
verilog/board_specific_top.sv
testbench/board_specific_top_props.sv
testbench/tb_board_specific_top.sv

// ==== testbench/tb_board_specific_top.sv ====
`timescale 1ns/100ps

module tb_board_specific_top;
    import board_audio_pkg::*;

    logic clk = 1'b0;
    logic reset;
    key_t key_sw;
    logic sd;
    led_t led;
    logic lr;
    logic ws;
    logic sck;
    logic mclk;
    logic bclk;
    logic lrclk;
    logic sdata;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rnd_state = 32'd68959;

    mic_sample_t   next_word = '0;          // Taken by the mic model at frame start
    mic_sample_t   cur_word;
    int            mic_pos;
    int            mic_frame;
    logic          prev_sck;
    logic          prev_ws;

    int            out_pos;
    int            out_frame;
    logic          prev_bclk;
    logic          prev_lrclk;
    logic [15:0]   out_shift;
    sound_sample_t out_word [int];          // Left word per output frame

    always #4 clk = ~clk;

    board_specific_top i_board_specific_top (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .key_sw ( key_sw ),
        .sd     ( sd     ),
        .led    ( led    ),
        .lr     ( lr     ),
        .ws     ( ws     ),
        .sck    ( sck    ),
        .mclk   ( mclk   ),
        .bclk   ( bclk   ),
        .lrclk  ( lrclk  ),
        .sdata  ( sdata  )
    );

    // --------------------------------------------------
    // INMP441 model with a new bit after each falling sck

    always @(negedge clk) begin
        if (reset) begin
            mic_pos   = 0;
            mic_frame = 0;
            cur_word  = '0;
            prev_sck  = 1'b0;
            prev_ws   = 1'b0;
            sd        = 1'b0;
        end else begin
            if (prev_sck && !sck) begin
                if (prev_ws && !ws) begin           // Frame start
                    mic_pos   = 0;
                    mic_frame = mic_frame + 1;
                    cur_word  = next_word;
                end else begin
                    mic_pos = mic_pos + 1;
                end
            end
            if (mic_pos >= 1 && mic_pos <= w_mic)
                sd = cur_word[w_mic - mic_pos];     // MSB first
            else
                sd = 1'b0;
            prev_sck = sck;
            prev_ws  = ws;
        end
    end

    // --------------------------------------------------
    // I2S output decoder for the left word only

    always @(negedge clk) begin
        if (reset) begin
            out_pos    = 0;
            out_frame  = 0;
            prev_bclk  = 1'b0;
            prev_lrclk = 1'b0;
        end else begin
            if (prev_bclk && !bclk) begin
                if (prev_lrclk && !lrclk) begin
                    out_pos   = 0;
                    out_frame = out_frame + 1;
                end else begin
                    out_pos = out_pos + 1;
                end
            end
            if (!prev_bclk && bclk && !lrclk && out_pos >= 1 && out_pos <= w_sound) begin
                out_shift = {out_shift[w_sound - 2:0], sdata};
                if (out_pos == w_sound)
                    out_word[out_frame] = out_shift;
            end
            prev_bclk  = bclk;
            prev_lrclk = lrclk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Shift right by 8 - gain and clamp to the 16-bit signed range
    function automatic sound_sample_t expected_sound(input mic_sample_t m, input int gain);
        longint v;
        v = longint'(m);
        v = v >>> (8 - gain);
        if (v > 32767)
            v = 32767;
        else if (v < -32768)
            v = -32768;
        return v[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout at time %0t while waiting for %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        $display("%s finished, %0d errors so far", name, errors);
    endtask

    // --------------------------------------------------
    // Stimulus and waits

    task automatic send_frame(input mic_sample_t word, input gain_t gain, input bit mute,
                              output int frame);
        int n;
        n = 0;
        while (mic_pos != 30 && n < 2048) begin     // Safely after bit 24
            @(negedge clk);
            n++;
        end
        if (mic_pos != 30)
            report_timeout("mic bit 30");
        next_word = word;
        key_sw    = ~{1'b0, mute, gain};
        frame     = mic_frame + 1;
        n = 0;
        while (mic_pos == 30 && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (mic_pos == 30)
            report_timeout("mic bit 31");
    endtask

    task automatic wait_frame(input int frame);
        int n;
        n = 0;
        while (mic_frame < frame && n < 4096) begin
            @(negedge clk);
            n++;
        end
        if (mic_frame < frame)
            report_timeout("next mic frame");
    endtask

    task automatic expect_word(input int frame, input sound_sample_t expected);
        int n;
        n = 0;
        while (!out_word.exists(frame) && n < 4096) begin
            @(negedge clk);
            n++;
        end
        if (!out_word.exists(frame))
            report_timeout("output word");
        else
            check_value("sdata word", expected, out_word[frame]);
    endtask

    task automatic wait_leds(input led_t target, input int limit);
        int n;
        n = 0;
        while (led !== target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (led !== target)
            report_timeout("LED pattern");
    endtask

    // Clocks between two rising mclk edges
    task automatic check_mclk_period();
        int   n;
        int   edges;
        int   period;
        logic prev;
        n      = 0;
        edges  = 0;
        period = 0;
        prev   = mclk;
        while (edges < 2 && n < 32) begin
            @(negedge clk);
            n++;
            if (edges == 1)
                period++;
            if (mclk && !prev)
                edges++;
            prev = mclk;
        end
        if (edges < 2)
            report_timeout("two rising mclk edges");
        else
            check_value("mclk period", 4, period);
    endtask

    // --------------------------------------------------
    // Tests

    task automatic after_reset();
        int  n;
        bit  seen_high;
        seen_high = 1'b0;
        n = 0;
        check_value("led", 4'hF, led);
        check_value("lr", 1'b0, lr);
        while (out_frame == 0 && n < 2048) begin
            if (sdata !== 1'b0)
                seen_high = 1'b1;
            @(negedge clk);
            n++;
        end
        if (out_frame == 0)
            report_timeout("end of first frame");
        check_value("sdata high in frame 0", 1'b0, seen_high);
        check_mclk_period();
        finish_test("after_reset");
    endtask

    task automatic mute_silences_output();
        int f;
        for (int i = 0; i < 4; i++) begin
            rnd_state = xorshift(rnd_state);
            send_frame(rnd_state[23:0], 2'd3, 1'b1, f);
            expect_word(f + 1, '0);
            check_value("led", 4'hF, led);
        end
        finish_test("mute_silences_output");
    endtask

    task automatic loopback_random();
        mic_sample_t samples [8];
        int          frames [8];
        for (int i = 0; i < 8; i++) begin
            rnd_state  = xorshift(rnd_state);
            samples[i] = rnd_state[23:0];
            send_frame(samples[i], 2'd0, 1'b0, frames[i]);
        end
        for (int i = 0; i < 8; i++)
            expect_word(frames[i] + 1, expected_sound(samples[i], 0));
        finish_test("loopback_random");
    endtask

    task automatic gain_saturation();
        int f;
        send_frame(24'h7F0000, 2'd3, 1'b0, f);
        expect_word(f + 1, 16'h7FFF);               // Positive limit
        send_frame(24'h810000, 2'd3, 1'b0, f);
        expect_word(f + 1, 16'h8000);               // Negative limit
        send_frame(24'h000123, 2'd3, 1'b0, f);
        expect_word(f + 1, 16'd9);                  // 0x123 / 32
        send_frame(-24'sd1000, 2'd2, 1'b0, f);
        expect_word(f + 1, 16'hFFF0);               // floor(-1000 / 64)
        finish_test("gain_saturation");
    endtask

    task automatic meter_rise_and_decay();
        int f;
        wait_leds(4'hF, 20 * decay_cycles);         // Peak left over from earlier tests
        send_frame(24'h7FFFFF, 2'd0, 1'b0, f);
        wait_frame(f + 1);
        check_value("led", 4'h0, led);
        send_frame('0, 2'd0, 1'b0, f);
        wait_leds(4'hF, 20 * decay_cycles);
        check_value("led", 4'hF, led);
        finish_test("meter_rise_and_decay");
    endtask

    initial begin
        reset  = 1'b1;
        key_sw = '1;                                // No key pressed
        sd     = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        after_reset();
        mute_silences_output();
        loopback_random();
        gain_saturation();
        meter_rise_and_decay();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== testbench/board_specific_top_props.sv ====
`timescale 1ns/100ps

module board_specific_top_props
    import board_audio_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input logic          mic_valid,
    input logic          sound_valid,
    input sound_sample_t sound,
    input logic          mute,
    input logic          bclk,
    input logic          lrclk,
    input led_t          led
);

    // --------------------------------------------------
    // Strobes and clocks

    a_mic_pulse: assert property (@(posedge clk) disable iff (reset) mic_valid |=> !mic_valid)
        else $error("mic_valid held longer than one cycle");

    a_sound_pulse: assert property (@(posedge clk) disable iff (reset)
                                    sound_valid |=> !sound_valid)
        else $error("sound_valid held longer than one cycle");

    a_lrclk_edge: assert property (@(posedge clk) disable iff (reset)
                                   $changed(lrclk) |-> $fell(bclk))
        else $error("lrclk moved away from a falling bclk");

    // LEDs dark at the pins right after reset
    a_led_reset: assert property (@(posedge clk) reset |=> (led == '1))
        else $error("LEDs lit after reset");

    a_mute_zero: assert property (@(posedge clk) disable iff (reset)
                                  (sound_valid && $past(mute)) |-> (sound == '0))
        else $error("nonzero sound while muted");

endmodule

bind board_specific_top board_specific_top_props i_props (
    .clk         ( clk         ),
    .reset       ( reset       ),
    .mic_valid   ( mic_valid   ),
    .sound_valid ( sound_valid ),
    .sound       ( sound       ),
    .mute        ( mute        ),
    .bclk        ( bclk        ),
    .lrclk       ( lrclk       ),
    .led         ( led         )
);

// ==== verilog/board_specific_top.sv ====
`timescale 1ns/100ps

module board_specific_top
    import board_audio_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  key_t key_sw,                    // Active low at the pins
    input  logic sd,                        // INMP441 data

    output led_t led,                       // Active low at the pins
    output logic lr,
    output logic ws,
    output logic sck,
    output logic mclk,
    output logic bclk,
    output logic lrclk,
    output logic sdata
);

    // --------------------------------------------------
    // Board polarity

    key_t          key;
    gain_t         gain;
    logic          mute;
    led_t          lab_led;

    mic_sample_t   mic;
    logic          mic_valid;
    sound_sample_t sound;
    logic          sound_valid;

    assign key  = ~ key_sw;
    assign gain = key[1:0];
    assign mute = key[2];
    assign led  = ~ lab_led;

    // --------------------------------------------------
    // Audio pipeline

    inmp441_mic_i2s_receiver i_microphone (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .sd          ( sd          ),
        .lr          ( lr          ),
        .ws          ( ws          ),
        .sck         ( sck         ),
        .mic         ( mic         ),
        .mic_valid   ( mic_valid   )
    );

    sound_gain_stage i_gain (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .mic         ( mic         ),
        .mic_valid   ( mic_valid   ),
        .gain        ( gain        ),
        .mute        ( mute        ),
        .sound       ( sound       ),
        .sound_valid ( sound_valid )
    );

    level_meter i_level_meter (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .sound       ( sound       ),
        .sound_valid ( sound_valid ),
        .led         ( lab_led     )
    );

    i2s_audio_out i_audio_out (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .sound       ( sound       ),
        .sound_valid ( sound_valid ),
        .mclk        ( mclk        ),
        .bclk        ( bclk        ),
        .lrclk       ( lrclk       ),
        .sdata       ( sdata       )
    );

endmodule

// ==== verilog/i2s_audio_out.sv ====
`timescale 1ns/100ps

module i2s_audio_out
    import board_audio_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  sound_sample_t sound,
    input  logic          sound_valid,

    output logic          mclk,
    output logic          bclk,
    output logic          lrclk,
    output logic          sdata
);

    typedef enum logic [1:0] {st_idle, st_left, st_right} state_t;

    state_t state;

    logic [1:0]                          mclk_div;
    logic [$clog2(clk_per_bit)    - 1:0] cyc;
    logic [$clog2(bits_per_frame) - 1:0] bit_idx;
    logic [$clog2(bits_per_frame) - 1:0] next_bit;

    logic mid_cyc;
    logic last_cyc;                         // bclk falls, sdata moves
    logic load_left;
    logic load_right;
    logic shift_out;

    sound_sample_t hold;                    // Latest sample from the gain stage
    sound_sample_t frame_word;              // Sample of the current frame
    sound_sample_t shreg;

    assign mclk = mclk_div[1];              // clk / 4

    always_comb begin
        mid_cyc  = (cyc == clk_per_bit / 2 - 1);
        last_cyc = (cyc == clk_per_bit - 1);

        if (bit_idx == bits_per_frame - 1)
            next_bit = '0;
        else
            next_bit = bit_idx + 1'b1;

        load_left  = last_cyc && (next_bit == 0);
        load_right = last_cyc && (next_bit == bits_per_frame / 2) && (state == st_left);
        shift_out  = last_cyc && !load_left && (next_bit != bits_per_frame / 2)
                     && (state != st_idle);
    end

    // --------------------------------------------------
    // Dividers and channel FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            mclk_div <= '0;
            cyc      <= '0;
            bit_idx  <= '0;
            bclk     <= 1'b0;
            lrclk    <= 1'b0;
            sdata    <= 1'b0;
            state    <= st_idle;
        end else begin
            mclk_div <= mclk_div + 1'b1;

            if (last_cyc)
                cyc <= '0;
            else
                cyc <= cyc + 1'b1;

            if (mid_cyc)
                bclk <= 1'b1;

            if (last_cyc) begin
                bclk    <= 1'b0;
                bit_idx <= next_bit;
                lrclk   <= (next_bit >= bits_per_frame / 2);
                sdata   <= shift_out ? shreg[w_sound - 1] : 1'b0;  // Gap bit is zero
            end

            if (load_left)
                state <= st_left;           // Leaves idle at first frame start
            else if (load_right)
                state <= st_right;
        end
    end

    // --------------------------------------------------
    // Sample path

    always_ff @(posedge clk) begin
        if (sound_valid)
            hold <= sound;

        if (load_left) begin
            frame_word <= hold;
            shreg      <= hold;
        end else if (load_right) begin
            shreg <= frame_word;            // Same word on the right channel
        end else if (shift_out) begin
            shreg <= shreg << 1;            // Zeros after the 16th bit
        end
    end

endmodule

// ==== verilog/level_meter.sv ====
`timescale 1ns/100ps

module level_meter
    import board_audio_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  sound_sample_t sound,
    input  logic          sound_valid,

    output led_t          led
);

    logic [w_sound - 1:0] magnitude;        // -32768 maps to 32768
    logic [w_sound - 1:0] peak;
    logic [w_sound - 1:0] base;             // Peak after any decay step

    logic [$clog2(decay_cycles) - 1:0] decay_cnt;
    logic decay_tick;

    always_comb begin
        if (sound[w_sound - 1])
            magnitude = -sound;
        else
            magnitude = sound;

        decay_tick = (decay_cnt == decay_cycles - 1);

        if (decay_tick)
            base = peak >> 1;
        else
            base = peak;
    end

    // --------------------------------------------------
    // Peak hold with decay

    always_ff @(posedge clk) begin
        if (reset) begin
            decay_cnt <= '0;
            peak      <= '0;
        end else begin
            if (decay_tick)
                decay_cnt <= '0;
            else
                decay_cnt <= decay_cnt + 1'b1;

            if (sound_valid && (magnitude > base))
                peak <= magnitude;
            else
                peak <= base;
        end
    end

    // Bar graph, bit i at 2 ** (11 + i)
    always_comb begin
        for (int i = 0; i < w_led; i++)
            led[i] = (peak >> (w_sound - 1 - w_led + i)) != '0;
    end

endmodule

// ==== verilog/sound_gain_stage.sv ====
`timescale 1ns/100ps

module sound_gain_stage
    import board_audio_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  mic_sample_t   mic,
    input  logic          mic_valid,
    input  gain_t         gain,
    input  logic          mute,

    output sound_sample_t sound,
    output logic          sound_valid
);

    logic [4:0]    shift_amt;
    mic_sample_t   shifted;
    logic          fits;                    // Upper bits are all sign copies
    sound_sample_t saturated;

    // --------------------------------------------------
    // Shift and saturate

    always_comb begin
        // Gain 0 drops 8 bits, gain 3 drops 5
        shift_amt = 5'(w_mic - w_sound) - 5'(gain);
        shifted   = mic >>> shift_amt;      // Arithmetic, keeps sign

        fits = (shifted[w_mic - 1:w_sound - 1]
                == {(w_mic - w_sound + 1){shifted[w_mic - 1]}});

        if (fits)
            saturated = shifted[w_sound - 1:0];
        else
            saturated = {shifted[w_mic - 1], {(w_sound - 1){~shifted[w_mic - 1]}}};
    end

    // --------------------------------------------------
    // Output register

    always_ff @(posedge clk) begin
        if (mic_valid) begin
            if (mute)
                sound <= '0;
            else
                sound <= saturated;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            sound_valid <= 1'b0;
        else
            sound_valid <= mic_valid;       // Strobe passes even when muted
    end

endmodule

// ==== verilog/inmp441_mic_i2s_receiver.sv ====
`timescale 1ns/100ps

module inmp441_mic_i2s_receiver
    import board_audio_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        sd,

    output logic        lr,
    output logic        ws,
    output logic        sck,
    output mic_sample_t mic,
    output logic        mic_valid
);

    // --------------------------------------------------
    // Bit period and frame position

    logic [$clog2(clk_per_bit)    - 1:0] cyc;
    logic [$clog2(bits_per_frame) - 1:0] bit_idx;
    logic [$clog2(bits_per_frame) - 1:0] next_bit;

    logic mid_cyc;                          // sck rises after this cycle
    logic last_cyc;                         // sck falls after this cycle
    logic data_bit;                         // Bits 1 to 24 of the left slot

    logic [w_mic - 2:0] shreg;              // The last bit goes straight to mic

    assign lr = 1'b0;                       // Mic answers in the left slot

    always_comb begin
        mid_cyc  = (cyc == clk_per_bit / 2 - 1);
        last_cyc = (cyc == clk_per_bit - 1);

        if (bit_idx == bits_per_frame - 1)
            next_bit = '0;
        else
            next_bit = bit_idx + 1'b1;

        data_bit = (bit_idx >= 1) && (bit_idx <= w_mic);
    end

    // --------------------------------------------------
    // Clock generation

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc     <= '0;
            bit_idx <= '0;
            sck     <= 1'b0;
            ws      <= 1'b0;
        end else begin
            if (last_cyc)
                cyc <= '0;
            else
                cyc <= cyc + 1'b1;

            if (mid_cyc)
                sck <= 1'b1;

            if (last_cyc) begin
                sck     <= 1'b0;
                bit_idx <= next_bit;
                ws      <= (next_bit >= bits_per_frame / 2);  // High in right half
            end
        end
    end

    // --------------------------------------------------
    // Capture on rising sck

    always_ff @(posedge clk) begin
        if (mid_cyc && data_bit) begin
            shreg <= {shreg[w_mic - 3:0], sd};             // MSB first
            if (bit_idx == w_mic)
                mic <= {shreg, sd};                        // Word complete
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            mic_valid <= 1'b0;
        else
            mic_valid <= mid_cyc && (bit_idx == w_mic);    // Same edge as mic
    end

endmodule

// ==== verilog/board_audio_pkg.sv ====
package board_audio_pkg;

    // --------------------------------------------------
    // Clocking and I2S framing

    localparam int clk_mhz        = 50;     // System clock
    localparam int clk_per_bit    = 16;     // Clocks per I2S bit period
    localparam int bits_per_frame = 64;     // Two 32-bit channel slots

    // --------------------------------------------------
    // Sample widths

    localparam int w_mic   = 24;            // INMP441 word
    localparam int w_sound = 16;            // DAC word

    // --------------------------------------------------
    // Board I/O

    localparam int w_key = 4;
    localparam int w_led = 4;

    // Peak halves once per this many clocks, about 1.3 ms
    localparam int decay_cycles = 65536;

    // --------------------------------------------------
    // Types

    typedef logic signed [w_mic   - 1:0] mic_sample_t;
    typedef logic signed [w_sound - 1:0] sound_sample_t;

    typedef logic [1:0] gain_t;             // 0 means shift by 8

    typedef logic [w_key - 1:0] key_t;      // Active high inside the design
    typedef logic [w_led - 1:0] led_t;

endpackage
